//--- pl3_mem_settings.svh
`ifndef PL3_MEM_SETTINGS_SVH
`define PL3_MEM_SETTINGS_SVH

// Datapath word width in bits.
`define PL3_DATA_W 32

// Data memory depth and word-index width.
`define PL3_MEM_WORDS 256
`define PL3_MEM_AW 8

// Register-file address width.
`define PL3_REG_AW 5

`endif

//--- pl3_mem_pkg.sv
`include "pl3_mem_settings.svh"

package pl3_mem_pkg;

    // Access size of a load or store. Codes 5 to 7 are unused.
    typedef enum logic [2:0]
    {
        L_S_BYTE   = 3'd0,
        L_S_HALF   = 3'd1,
        L_S_WORD   = 3'd2,
        L_S_BYTE_U = 3'd3,
        L_S_HALF_U = 3'd4
    } l_s_sel;

    typedef logic [`PL3_DATA_W-1:0] data_val;

    typedef logic [`PL3_REG_AW-1:0] reg_addr;

    // One memory word, seen whole or by byte or half lanes.
    typedef union packed
    {
        logic [`PL3_DATA_W-1:0]            word;
        logic [`PL3_DATA_W/8-1:0][7:0]     bytes;
        logic [`PL3_DATA_W/16-1:0][15:0]   halves;
    } mem_word_u;

endpackage

//--- main_mem.sv
`timescale 1ns/1ns
`include "pl3_mem_settings.svh"

module main_mem
(
    input  logic                    i_clk,
    input  logic [`PL3_MEM_AW-1:0]  i_rd_idx,
    input  logic                    i_wr_en,
    input  logic [`PL3_MEM_AW-1:0]  i_wr_idx,
    input  pl3_mem_pkg::mem_word_u  i_wr_word,

    output pl3_mem_pkg::mem_word_u  o_rd_word
);

    logic [`PL3_DATA_W-1:0] mem [`PL3_MEM_WORDS];

    logic                   wr_hits_rd;

    initial
    begin
        for (int i = 0; i < `PL3_MEM_WORDS; i++)
        begin
            mem[i] = '0;
        end
    end

    assign wr_hits_rd = i_wr_en && (i_wr_idx == i_rd_idx);

    always_ff @(posedge i_clk)
    begin
        if (i_wr_en)
        begin
            mem[i_wr_idx] <= i_wr_word.word;
        end
    end

    // Same-cycle write wins over the stored word.
    always_ff @(posedge i_clk)
    begin
        if (wr_hits_rd)
        begin
            o_rd_word <= i_wr_word;
        end
        else
        begin
            o_rd_word.word <= mem[i_rd_idx];
        end
    end

    a_wr_en_known: assert property (@(posedge i_clk) !$isunknown(i_wr_en))
        else $error("main_mem: write enable is unknown");

endmodule

//--- mem_protect_regs.sv
`timescale 1ns/1ns
`include "pl3_mem_settings.svh"

module mem_protect_regs
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_cfg_wr,
    input  logic [`PL3_MEM_AW-1:0]  i_cfg_limit,
    input  logic                    i_st_en,
    input  logic [`PL3_MEM_AW-1:0]  i_st_idx,

    output logic                    o_mem_wr_en,
    output logic                    o_store_fault,
    output logic [7:0]              o_fault_count
);

    logic [`PL3_MEM_AW-1:0] limit;
    logic                   blocked;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            limit <= '0;
        end
        else if (i_cfg_wr)
        begin
            limit <= i_cfg_limit;
        end
    end

    assign blocked       = i_st_en && (i_st_idx < limit);
    assign o_mem_wr_en   = i_st_en && !blocked;
    assign o_store_fault = blocked;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_fault_count <= '0;
        end
        else if (blocked && !(&o_fault_count))
        begin
            o_fault_count <= o_fault_count + 8'd1; // Holds at 255.
        end
    end

    a_st_idx_known: assert property (
        @(posedge i_clk) disable iff (i_rst) i_st_en |-> !$isunknown(i_st_idx))
        else $error("mem_protect_regs: store index unknown on a store request");

endmodule

//--- pl3_mem.sv
`timescale 1ns/1ns
`include "pl3_mem_settings.svh"

module pl3_mem
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  pl3_mem_pkg::data_val    i_alu_out_val,
    input  logic                    i_mem_wr_en,
    input  pl3_mem_pkg::data_val    i_mem_wr_val,
    input  logic                    i_mem_rd_en,
    input  pl3_mem_pkg::l_s_sel     i_l_s_sel_val,
    input  pl3_mem_pkg::reg_addr    i_ff_addr,
    input  pl3_mem_pkg::mem_word_u  i_rd_word,

    output logic [`PL3_MEM_AW-1:0]  o_rd_idx,
    output logic                    o_st_en,
    output logic [`PL3_MEM_AW-1:0]  o_st_idx,
    output pl3_mem_pkg::mem_word_u  o_st_word,
    output pl3_mem_pkg::data_val    o_mem_rd_val,
    output pl3_mem_pkg::reg_addr    o_ff_addr,
    output pl3_mem_pkg::data_val    o_ff_val
);

    logic                       mem_rd_en_d1;
    logic                       mem_wr_en_d1;
    pl3_mem_pkg::l_s_sel        l_s_sel_val_d1;
    pl3_mem_pkg::data_val       alu_out_val_d1;
    pl3_mem_pkg::data_val       mem_wr_val_d1;
    logic [1:0]                 lane_d1;
    logic [`PL3_MEM_AW-1:0]     idx_d1;
    pl3_mem_pkg::data_val       ld_val;
    logic                       st_size_ok;

    // Word index of the access, byte offset dropped.
    assign o_rd_idx = i_alu_out_val[`PL3_MEM_AW+1:2];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            mem_rd_en_d1 <= 1'b0;
            mem_wr_en_d1 <= 1'b0;
        end
        else
        begin
            mem_rd_en_d1 <= i_mem_rd_en;
            mem_wr_en_d1 <= i_mem_wr_en;
        end
    end

    always_ff @(posedge i_clk)
    begin
        l_s_sel_val_d1 <= i_l_s_sel_val;
        alu_out_val_d1 <= i_alu_out_val;
        mem_wr_val_d1  <= i_mem_wr_val;
        lane_d1        <= i_alu_out_val[1:0];
        idx_d1         <= i_alu_out_val[`PL3_MEM_AW+1:2];
        o_ff_addr      <= i_ff_addr;
        o_mem_rd_val   <= o_ff_val;
    end

    // Lane pick and extension of the word read in the previous cycle.
    always_comb
    begin
        ld_val = '0;
        case (l_s_sel_val_d1)
            pl3_mem_pkg::L_S_BYTE:
                ld_val = pl3_mem_pkg::data_val'($signed(i_rd_word.bytes[lane_d1]));
            pl3_mem_pkg::L_S_HALF:
                ld_val = pl3_mem_pkg::data_val'($signed(i_rd_word.halves[lane_d1[1]]));
            pl3_mem_pkg::L_S_WORD:
                ld_val = i_rd_word.word;
            pl3_mem_pkg::L_S_BYTE_U:
                ld_val = pl3_mem_pkg::data_val'(i_rd_word.bytes[lane_d1]);
            pl3_mem_pkg::L_S_HALF_U:
                ld_val = pl3_mem_pkg::data_val'(i_rd_word.halves[lane_d1[1]]);
            default:
                ld_val = '0;
        endcase
    end

    assign o_ff_val = mem_rd_en_d1 ? ld_val : alu_out_val_d1;

    // Merge of the store data into the old word.
    always_comb
    begin
        o_st_word  = i_rd_word;
        st_size_ok = 1'b1;
        case (l_s_sel_val_d1)
            pl3_mem_pkg::L_S_BYTE, pl3_mem_pkg::L_S_BYTE_U:
                o_st_word.bytes[lane_d1] = mem_wr_val_d1[7:0];
            pl3_mem_pkg::L_S_HALF, pl3_mem_pkg::L_S_HALF_U:
                o_st_word.halves[lane_d1[1]] = mem_wr_val_d1[15:0];
            pl3_mem_pkg::L_S_WORD:
                o_st_word.word = mem_wr_val_d1;
            default:
                st_size_ok = 1'b0; // Unused code, no store.
        endcase
    end

    assign o_st_en  = mem_wr_en_d1 && st_size_ok;
    assign o_st_idx = idx_d1;

    a_rd_wr_excl: assert property (
        @(posedge i_clk) disable iff (i_rst) !(i_mem_rd_en && i_mem_wr_en))
        else $error("pl3_mem: read and write enables high together");

endmodule

//--- pl3_mem_top.sv
`timescale 1ns/1ns
`include "pl3_mem_settings.svh"

module pl3_mem_top
(
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  pl3_mem_pkg::data_val    i_alu_out_val,
    input  logic                    i_mem_wr_en,
    input  pl3_mem_pkg::data_val    i_mem_wr_val,
    input  logic                    i_mem_rd_en,
    input  pl3_mem_pkg::l_s_sel     i_l_s_sel_val,
    input  pl3_mem_pkg::reg_addr    i_ff_addr,
    input  logic                    i_cfg_wr,
    input  logic [`PL3_MEM_AW-1:0]  i_cfg_limit,

    output pl3_mem_pkg::data_val    o_mem_rd_val,
    output pl3_mem_pkg::reg_addr    o_ff_addr,
    output pl3_mem_pkg::data_val    o_ff_val,
    output logic                    o_store_fault,
    output logic [7:0]              o_fault_count
);

    logic [`PL3_MEM_AW-1:0]     rd_idx;
    pl3_mem_pkg::mem_word_u     rd_word;
    logic                       st_en;
    logic [`PL3_MEM_AW-1:0]     st_idx;
    pl3_mem_pkg::mem_word_u     st_word;
    logic                       mem_wr_en;

    pl3_mem pl3_mem_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_alu_out_val (i_alu_out_val),
        .i_mem_wr_en   (i_mem_wr_en),
        .i_mem_wr_val  (i_mem_wr_val),
        .i_mem_rd_en   (i_mem_rd_en),
        .i_l_s_sel_val (i_l_s_sel_val),
        .i_ff_addr     (i_ff_addr),
        .i_rd_word     (rd_word),
        .o_rd_idx      (rd_idx),
        .o_st_en       (st_en),
        .o_st_idx      (st_idx),
        .o_st_word     (st_word),
        .o_mem_rd_val  (o_mem_rd_val),
        .o_ff_addr     (o_ff_addr),
        .o_ff_val      (o_ff_val)
    );

    // Gates stores below the configured limit.
    mem_protect_regs mem_protect_regs_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_cfg_wr      (i_cfg_wr),
        .i_cfg_limit   (i_cfg_limit),
        .i_st_en       (st_en),
        .i_st_idx      (st_idx),
        .o_mem_wr_en   (mem_wr_en),
        .o_store_fault (o_store_fault),
        .o_fault_count (o_fault_count)
    );

    main_mem main_mem_i
    (
        .i_clk         (i_clk),
        .i_rd_idx      (rd_idx),
        .i_wr_en       (mem_wr_en),
        .i_wr_idx      (st_idx),
        .i_wr_word     (st_word),
        .o_rd_word     (rd_word)
    );

endmodule

//--- pl3_mem_tb.sv
`timescale 1ns/1ns
`include "pl3_mem_settings.svh"

module pl3_mem_tb;

    typedef logic [`PL3_MEM_AW-1:0] word_idx;

    logic                       i_clk;
    logic                       i_rst;
    pl3_mem_pkg::data_val       i_alu_out_val;
    logic                       i_mem_wr_en;
    pl3_mem_pkg::data_val       i_mem_wr_val;
    logic                       i_mem_rd_en;
    pl3_mem_pkg::l_s_sel        i_l_s_sel_val;
    pl3_mem_pkg::reg_addr       i_ff_addr;
    logic                       i_cfg_wr;
    word_idx                    i_cfg_limit;
    pl3_mem_pkg::data_val       o_mem_rd_val;
    pl3_mem_pkg::reg_addr       o_ff_addr;
    pl3_mem_pkg::data_val       o_ff_val;
    logic                       o_store_fault;
    logic [7:0]                 o_fault_count;

    pl3_mem_pkg::mem_word_u     shadow [`PL3_MEM_WORDS]; // Reference copy of the memory.
    word_idx                    limit_model;
    logic [7:0]                 count_model;

    // Expected outputs of the instruction now issued, then one and two cycles on.
    logic                       chk_next;
    logic                       chk_d1;
    logic                       chk_d2;
    pl3_mem_pkg::data_val       ff_next;
    pl3_mem_pkg::data_val       ff_d1;
    pl3_mem_pkg::data_val       ff_d2;
    pl3_mem_pkg::reg_addr       addr_next;
    pl3_mem_pkg::reg_addr       addr_d1;
    logic                       fault_next;
    logic                       fault_d1;
    logic [7:0]                 count_d1;
    logic [7:0]                 count_d2;

    pl3_mem_top pl3_mem_top_i
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_alu_out_val (i_alu_out_val),
        .i_mem_wr_en   (i_mem_wr_en),
        .i_mem_wr_val  (i_mem_wr_val),
        .i_mem_rd_en   (i_mem_rd_en),
        .i_l_s_sel_val (i_l_s_sel_val),
        .i_ff_addr     (i_ff_addr),
        .i_cfg_wr      (i_cfg_wr),
        .i_cfg_limit   (i_cfg_limit),
        .o_mem_rd_val  (o_mem_rd_val),
        .o_ff_addr     (o_ff_addr),
        .o_ff_val      (o_ff_val),
        .o_store_fault (o_store_fault),
        .o_fault_count (o_fault_count)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        if (i_rst)
        begin
            chk_d1 <= 1'b0;
            chk_d2 <= 1'b0;
        end
        else
        begin
            chk_d1 <= chk_next;
            chk_d2 <= chk_d1;
        end
        ff_d1    <= ff_next;
        ff_d2    <= ff_d1;
        addr_d1  <= addr_next;
        fault_d1 <= fault_next;
        count_d1 <= count_model;
        count_d2 <= count_d1;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    // Checked mid-cycle, where outputs and expectations are settled.
    a_ff_val: assert property (@(negedge i_clk) chk_d1 |-> o_ff_val == ff_d1)
        else begin
            $display("MISMATCH time=%0t o_ff_val got=%h expected=%h", $time, o_ff_val, ff_d1);
            abort_run();
        end

    a_ff_addr: assert property (@(negedge i_clk) chk_d1 |-> o_ff_addr == addr_d1)
        else begin
            $display("MISMATCH time=%0t o_ff_addr got=%h expected=%h", $time, o_ff_addr, addr_d1);
            abort_run();
        end

    a_mem_rd_val: assert property (@(negedge i_clk) chk_d2 |-> o_mem_rd_val == ff_d2)
        else begin
            $display("MISMATCH time=%0t o_mem_rd_val got=%h expected=%h",
                     $time, o_mem_rd_val, ff_d2);
            abort_run();
        end

    a_store_fault: assert property (@(negedge i_clk) chk_d1 |-> o_store_fault == fault_d1)
        else begin
            $display("MISMATCH time=%0t o_store_fault got=%b expected=%b",
                     $time, o_store_fault, fault_d1);
            abort_run();
        end

    a_fault_count: assert property (@(negedge i_clk) chk_d2 |-> o_fault_count == count_d2)
        else begin
            $display("MISMATCH time=%0t o_fault_count got=%0d expected=%0d",
                     $time, o_fault_count, count_d2);
            abort_run();
        end

    function automatic pl3_mem_pkg::data_val load_value(input pl3_mem_pkg::mem_word_u w,
        input pl3_mem_pkg::l_s_sel sel, input logic [1:0] lane);
        logic [7:0]  b;
        logic [15:0] h;
        b = w.bytes[lane];
        h = w.halves[lane[1]]; // Half lane from the upper offset bit.
        case (sel)
            pl3_mem_pkg::L_S_BYTE:   return {{24{b[7]}}, b};
            pl3_mem_pkg::L_S_HALF:   return {{16{h[15]}}, h};
            pl3_mem_pkg::L_S_WORD:   return w.word;
            pl3_mem_pkg::L_S_BYTE_U: return {24'd0, b};
            pl3_mem_pkg::L_S_HALF_U: return {16'd0, h};
            default:                 return '0;
        endcase
    endfunction

    function automatic pl3_mem_pkg::mem_word_u merge_store(input pl3_mem_pkg::mem_word_u old,
        input pl3_mem_pkg::l_s_sel sel, input logic [1:0] lane, input pl3_mem_pkg::data_val val);
        pl3_mem_pkg::mem_word_u w;
        w = old;
        case (sel)
            pl3_mem_pkg::L_S_BYTE, pl3_mem_pkg::L_S_BYTE_U: w.bytes[lane] = val[7:0];
            pl3_mem_pkg::L_S_HALF, pl3_mem_pkg::L_S_HALF_U: w.halves[lane[1]] = val[15:0];
            pl3_mem_pkg::L_S_WORD: w.word = val;
            default: w = old;
        endcase
        return w;
    endfunction

    function automatic pl3_mem_pkg::data_val word_addr(input int idx);
        pl3_mem_pkg::data_val a;
        a = $urandom();
        a[`PL3_MEM_AW+1:0] = {word_idx'(idx), 2'b00}; // Upper bits stay random.
        return a;
    endfunction

    // Drives one instruction for one cycle and records what it must produce.
    task automatic issue(input logic rd, input logic wr, input pl3_mem_pkg::l_s_sel sel,
        input pl3_mem_pkg::data_val addr, input pl3_mem_pkg::data_val wdata);
        pl3_mem_pkg::reg_addr dst;
        word_idx              idx;
        dst = pl3_mem_pkg::reg_addr'($urandom());
        idx = addr[`PL3_MEM_AW+1:2];
        i_alu_out_val = addr;
        i_mem_rd_en   = rd;
        i_mem_wr_en   = wr;
        i_mem_wr_val  = wdata;
        i_l_s_sel_val = sel;
        i_ff_addr     = dst;
        ff_next    = rd ? load_value(shadow[idx], sel, addr[1:0]) : addr;
        addr_next  = dst;
        chk_next   = 1'b1;
        fault_next = 1'b0;
        if (wr && sel inside {pl3_mem_pkg::L_S_BYTE, pl3_mem_pkg::L_S_HALF,
            pl3_mem_pkg::L_S_WORD, pl3_mem_pkg::L_S_BYTE_U, pl3_mem_pkg::L_S_HALF_U})
        begin
            if (idx < limit_model)
            begin
                fault_next = 1'b1;
                if (count_model != 8'hff)
                begin
                    count_model = count_model + 8'd1;
                end
            end
            else
            begin
                shadow[idx] = merge_store(shadow[idx], sel, addr[1:0], wdata);
            end
        end
        @(posedge i_clk);
        #1;
    endtask

    task automatic issue_nop();
        issue(1'b0, 1'b0, pl3_mem_pkg::L_S_WORD, $urandom(), $urandom());
    endtask

    task automatic random_op(input int max_idx);
        int                   kind;
        logic [2:0]           sel;
        pl3_mem_pkg::data_val addr;
        kind = $urandom_range(2, 0);
        sel  = ($urandom_range(9, 0) < 9) ? 3'($urandom_range(4, 0)) : 3'($urandom_range(7, 5));
        addr = $urandom();
        addr[`PL3_MEM_AW+1:2] = word_idx'($urandom_range(max_idx, 0));
        issue(kind == 1, kind == 2, pl3_mem_pkg::l_s_sel'(sel), addr, $urandom());
    endtask

    task automatic set_limit(input word_idx lim);
        i_cfg_wr    = 1'b1;
        i_cfg_limit = lim;
        limit_model = lim;
        issue_nop();
        i_cfg_wr    = 1'b0;
    endtask

    task automatic wait_fault_count(input logic [7:0] target);
        int n;
        n = 0;
        while (o_fault_count != target && n < 20)
        begin
            issue_nop();
            n++;
        end
        if (o_fault_count != target)
        begin
            $display("Timed out waiting for the fault count to reach %0d.", target);
            abort_run();
        end
    endtask

    initial
    begin
        void'($urandom(62));
        i_rst         = 1'b1;
        i_alu_out_val = '0;
        i_mem_wr_en   = 1'b0;
        i_mem_wr_val  = '0;
        i_mem_rd_en   = 1'b0;
        i_l_s_sel_val = pl3_mem_pkg::L_S_WORD;
        i_ff_addr     = '0;
        i_cfg_wr      = 1'b0;
        i_cfg_limit   = '0;
        chk_next      = 1'b0;
        ff_next       = '0;
        addr_next     = '0;
        fault_next    = 1'b0;
        limit_model   = '0;
        count_model   = '0;
        for (int i = 0; i < `PL3_MEM_WORDS; i++)
        begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        repeat (8) issue_nop();
        issue(1'b0, 1'b1, pl3_mem_pkg::L_S_WORD, word_addr(10), 32'hcafe_f00d);
        issue(1'b1, 1'b0, pl3_mem_pkg::L_S_WORD, word_addr(10), '0); // Through the bypass.
        issue_nop();
        issue(1'b1, 1'b0, pl3_mem_pkg::L_S_WORD, word_addr(10), '0);
        for (int lane = 0; lane < 4; lane++)
        begin
            issue(1'b0, 1'b1, pl3_mem_pkg::L_S_BYTE, word_addr(10) + lane, 32'h5a0 + lane);
            issue(1'b1, 1'b0, pl3_mem_pkg::L_S_WORD, word_addr(10), '0);
        end
        for (int lane = 0; lane < 4; lane += 2)
        begin
            issue(1'b0, 1'b1, pl3_mem_pkg::L_S_HALF, word_addr(11) + lane, 32'h8001 + lane);
            issue(1'b1, 1'b0, pl3_mem_pkg::L_S_WORD, word_addr(11), '0);
        end
        issue(1'b0, 1'b1, pl3_mem_pkg::L_S_WORD, word_addr(12), 32'h8081_7f80);
        for (int lane = 0; lane < 4; lane++)
        begin
            issue(1'b1, 1'b0, pl3_mem_pkg::L_S_BYTE, word_addr(12) + lane, '0);
            issue(1'b1, 1'b0, pl3_mem_pkg::L_S_BYTE_U, word_addr(12) + lane, '0);
            issue(1'b1, 1'b0, pl3_mem_pkg::L_S_HALF, word_addr(12) + lane, '0);
            issue(1'b1, 1'b0, pl3_mem_pkg::L_S_HALF_U, word_addr(12) + lane, '0);
        end
        repeat (400) random_op(15);

        set_limit(word_idx'(16));
        issue(1'b0, 1'b1, pl3_mem_pkg::L_S_WORD, word_addr(5), 32'h1234_5678); // Dropped.
        issue(1'b1, 1'b0, pl3_mem_pkg::L_S_WORD, word_addr(5), '0);
        issue(1'b0, 1'b1, pl3_mem_pkg::L_S_BYTE, word_addr(16) + 1, 32'h0000_00a5);
        issue(1'b1, 1'b0, pl3_mem_pkg::L_S_WORD, word_addr(16), '0);
        wait_fault_count(count_model);
        repeat (300) random_op(31);
        wait_fault_count(count_model);
        set_limit(word_idx'(0));
        repeat (100) random_op(31);
        repeat (3) issue_nop();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
pl3_mem_pkg.sv
main_mem.sv
mem_protect_regs.sv
pl3_mem.sv
pl3_mem_top.sv
pl3_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module pl3_mem_tb -f sources.f \
    -o pl3_mem_sim > build.log 2>&1 || { cat build.log; echo "Build failed."; exit 1; }
./obj_dir/pl3_mem_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed." \
    || { echo "Simulation failed."; exit 1; }
